//--- list.f
src/csr_engine_pkg.sv
src/response_ingress.sv
src/response_fifo.sv
src/csr_index_configure.sv
src/engine_csr_index.sv
verif/engine_csr_index_assertions.sv
verif/engine_csr_index_tb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module engine_csr_index_tb -f list.f -o sim_engine \
    && ./obj_dir/sim_engine > sim.log 2>&1 \
    || echo "Build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

//--- src/csr_engine_pkg.sv
package csr_engine_pkg;

    // ------------------------------
    // Widths and depths
    // ------------------------------
    localparam int DEST_ID_W         = 4;
    localparam int FIELD_SEL_W       = 3;
    localparam int DATA_W            = 32;
    localparam int NUM_FIELDS        = 6;
    localparam int FIFO_DEPTH        = 16;
    localparam int FIFO_ADDR_W       = 4;
    localparam int PROG_THRESH       = 8;
    localparam int RESET_BUSY_CYCLES = 4;
    localparam int BUSY_CNT_W        = $clog2(RESET_BUSY_CYCLES + 1);

    // Destination accepted by this engine
    localparam logic [DEST_ID_W-1:0] ENGINE_ID = DEST_ID_W'(3);

    typedef logic [FIFO_ADDR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_ADDR_W:0]   fifo_count_t;

    // ------------------------------
    // Field codes
    // ------------------------------
    // Codes 6 and 7 carry no field
    typedef enum logic [FIELD_SEL_W-1:0] {
        FIELD_INDEX_START   = 3'd0,
        FIELD_INDEX_END     = 3'd1,
        FIELD_ARRAY_POINTER = 3'd2,
        FIELD_ARRAY_SIZE    = 3'd3,
        FIELD_STRIDE        = 3'd4,
        FIELD_SHIFT         = 3'd5
    } field_sel_e;

    // ------------------------------
    // Packet and state structs
    // ------------------------------
    typedef struct packed {
        logic [DEST_ID_W-1:0]   dest_id;
        logic [FIELD_SEL_W-1:0] field_sel;
        logic [DATA_W-1:0]      data;
    } mem_response_payload_t;

    typedef struct packed {
        logic                  valid;
        mem_response_payload_t payload;
    } mem_response_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_state_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] index_start;
        logic [DATA_W-1:0] index_end;
        logic [DATA_W-1:0] array_pointer;
        logic [DATA_W-1:0] array_size;
        logic [DATA_W-1:0] stride;
        logic [DATA_W-1:0] shift;
    } csr_index_config_t;

endpackage

//--- src/csr_index_configure.sv
module csr_index_configure (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  response_pop_en,
    input  logic                                  pop_valid,
    input  csr_engine_pkg::mem_response_payload_t pop_payload,
    output logic                                  pop_req,
    output csr_engine_pkg::csr_index_config_t     config_out,
    output logic                                  done_out
);

    import csr_engine_pkg::*;

    logic [DATA_W-1:0]     field_q [NUM_FIELDS];
    logic [NUM_FIELDS-1:0] loaded_mask;
    logic                  config_done;
    logic                  field_hit;

    // Empty check lives in the FIFO
    assign pop_req = response_pop_en;

    // Codes past the last field are ignored
    assign field_hit = pop_valid && (pop_payload.field_sel < FIELD_SEL_W'(NUM_FIELDS));

    // ------------------------------
    // Field capture
    // ------------------------------
    // Later packet for a field overwrites the earlier one
    always_ff @(posedge ap_clk) begin
        if (field_hit) begin
            field_q[pop_payload.field_sel] <= pop_payload.data;
        end
    end

    // ------------------------------
    // Loaded mask and completion
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            loaded_mask <= '0;
            config_done <= 1'b0;
        end else begin
            if (field_hit) begin
                loaded_mask[pop_payload.field_sel] <= 1'b1;
            end
            // Sticky once all fields are in
            config_done <= config_done || (&loaded_mask);
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign config_out = '{
        valid:         config_done,
        index_start:   field_q[FIELD_INDEX_START],
        index_end:     field_q[FIELD_INDEX_END],
        array_pointer: field_q[FIELD_ARRAY_POINTER],
        array_size:    field_q[FIELD_ARRAY_SIZE],
        stride:        field_q[FIELD_STRIDE],
        shift:         field_q[FIELD_SHIFT]
    };

    assign done_out = config_done;

endmodule

//--- src/engine_csr_index.sv
module engine_csr_index (
    input  logic                              ap_clk,
    input  logic                              areset_csr_engine,
    input  csr_engine_pkg::mem_response_t     response_memory_in,
    input  logic                              response_pop_en,
    output csr_engine_pkg::fifo_state_t       fifo_state,
    output logic                              fifo_setup_signal,
    output csr_engine_pkg::csr_index_config_t config_out,
    output logic                              done_out
);

    import csr_engine_pkg::*;

    logic                  push_valid;
    mem_response_payload_t push_payload;
    logic                  pop_req;
    logic                  pop_valid;
    mem_response_payload_t pop_payload;

    // ------------------------------
    // Ingress register and filter
    // ------------------------------
    response_ingress u_response_ingress (
        .ap_clk             (ap_clk),
        .areset_csr_engine  (areset_csr_engine),
        .response_memory_in (response_memory_in),
        .push_valid         (push_valid),
        .push_payload       (push_payload)
    );

    // ------------------------------
    // Response buffer
    // ------------------------------
    response_fifo u_response_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .push_valid        (push_valid),
        .push_payload      (push_payload),
        .pop_req           (pop_req),
        .pop_valid         (pop_valid),
        .pop_payload       (pop_payload),
        .state             (fifo_state),
        .setup_busy        (fifo_setup_signal)
    );

    // ------------------------------
    // CSR-index field collection
    // ------------------------------
    csr_index_configure u_csr_index_configure (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_pop_en   (response_pop_en),
        .pop_valid         (pop_valid),
        .pop_payload       (pop_payload),
        .pop_req           (pop_req),
        .config_out        (config_out),
        .done_out          (done_out)
    );

endmodule

//--- src/response_fifo.sv
module response_fifo (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  push_valid,
    input  csr_engine_pkg::mem_response_payload_t push_payload,
    input  logic                                  pop_req,
    output logic                                  pop_valid,
    output csr_engine_pkg::mem_response_payload_t pop_payload,
    output csr_engine_pkg::fifo_state_t           state,
    output logic                                  setup_busy
);

    import csr_engine_pkg::*;

    mem_response_payload_t mem [FIFO_DEPTH];

    fifo_ptr_t             wr_ptr;
    fifo_ptr_t             rd_ptr;
    fifo_count_t           count;
    logic [BUSY_CNT_W-1:0] busy_cnt;
    logic                  wr_en;
    logic                  rd_en;

    // ------------------------------
    // Reset-busy period
    // ------------------------------
    // Counts down after reset; FIFO refuses traffic until it hits zero
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            busy_cnt <= BUSY_CNT_W'(RESET_BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign setup_busy = (busy_cnt != '0);

    // ------------------------------
    // State flags
    // ------------------------------
    assign state.full      = (count == fifo_count_t'(FIFO_DEPTH));
    assign state.empty     = (count == '0);
    assign state.prog_full = (count >= fifo_count_t'(PROG_THRESH));

    // Pushes on full or busy are dropped
    assign wr_en = push_valid && !state.full && !setup_busy;
    assign rd_en = pop_req && !state.empty && !setup_busy;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_payload;
        end
    end

    // Read data lines up with pop_valid
    always_ff @(posedge ap_clk) begin
        if (rd_en) begin
            pop_payload <= mem[rd_ptr];
        end
    end

endmodule

//--- src/response_ingress.sv
module response_ingress (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  csr_engine_pkg::mem_response_t         response_memory_in,
    output logic                                  push_valid,
    output csr_engine_pkg::mem_response_payload_t push_payload
);

    import csr_engine_pkg::*;

    logic                  valid_q;
    mem_response_payload_t payload_q;

    // ------------------------------
    // Input register stage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= response_memory_in.valid;
        end
    end

    // Payload only matters when valid_q is set
    always_ff @(posedge ap_clk) begin
        payload_q <= response_memory_in.payload;
    end

    // ------------------------------
    // Destination filter
    // ------------------------------
    // Packets for other engines never reach the FIFO
    assign push_valid   = valid_q && (payload_q.dest_id == ENGINE_ID);
    assign push_payload = payload_q;

endmodule

//--- verif/engine_csr_index_assertions.sv
module engine_csr_index_assertions (
    input logic                              ap_clk,
    input logic                              areset_csr_engine,
    input csr_engine_pkg::fifo_state_t       fifo_state,
    input csr_engine_pkg::csr_index_config_t config_out,
    input logic                              done_out
);

    timeunit 1ns;
    timeprecision 100ps;

    // Both flags come from one occupancy count
    full_empty_exclusive: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(fifo_state.full && fifo_state.empty))
        else $error("FIFO flags full and empty are high together");

    // Done is sticky until the next reset
    done_sticky: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        done_out |=> done_out)
        else $error("done_out fell without a reset");

    done_matches_valid: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        done_out == config_out.valid)
        else $error("done_out differs from config_out.valid");

endmodule

bind engine_csr_index engine_csr_index_assertions u_engine_csr_index_assertions (
    .ap_clk            (ap_clk),
    .areset_csr_engine (areset_csr_engine),
    .fifo_state        (fifo_state),
    .config_out        (config_out),
    .done_out          (done_out)
);

//--- verif/engine_csr_index_tb.sv
module engine_csr_index_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import csr_engine_pkg::*;

    localparam int LOAD_ROWS      = 10;
    localparam int NUM_ROWS       = LOAD_ROWS + 1;
    localparam int EXTRA_PACKETS  = 4;
    localparam int TIMEOUT_CYCLES = 200;

    localparam int COND_SETUP_DONE = 0;
    localparam int COND_DONE       = 1;
    localparam int COND_EMPTY      = 2;
    localparam int COND_PROG_FULL  = 3;
    localparam int COND_FULL       = 4;
    localparam int COND_STRIDE     = 5;
    localparam int COND_SHIFT      = 6;

    // One stimulus row; accept means the row changes the configuration
    typedef struct packed {
        logic [DEST_ID_W-1:0]   dest_id;
        logic [FIELD_SEL_W-1:0] field_sel;
        logic [DATA_W-1:0]      data;
        logic                   accept;
    } stim_row_t;

    logic              ap_clk;
    logic              areset_csr_engine;
    mem_response_t     response_memory_in;
    logic              response_pop_en;
    fifo_state_t       fifo_state;
    logic              fifo_setup_signal;
    csr_index_config_t config_out;
    logic              done_out;

    stim_row_t         stim_table [NUM_ROWS];
    logic [DATA_W-1:0] exp_field [NUM_FIELDS];
    integer            seed;
    int                mismatch_count;
    int                timeout_count;

    engine_csr_index DUT (
        .ap_clk             (ap_clk),
        .areset_csr_engine  (areset_csr_engine),
        .response_memory_in (response_memory_in),
        .response_pop_en    (response_pop_en),
        .fifo_state         (fifo_state),
        .fifo_setup_signal  (fifo_setup_signal),
        .config_out         (config_out),
        .done_out           (done_out)
    );

    initial ap_clk = 1'b0;
    always #2 ap_clk = ~ap_clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            mismatch_count++;
        end
    endtask

    function automatic logic cond_met(input int cond);
        case (cond)
            COND_SETUP_DONE: cond_met = !fifo_setup_signal;
            COND_DONE:       cond_met = done_out;
            COND_EMPTY:      cond_met = fifo_state.empty;
            COND_PROG_FULL:  cond_met = fifo_state.prog_full;
            COND_FULL:       cond_met = fifo_state.full;
            COND_STRIDE:     cond_met = (config_out.stride == exp_field[FIELD_STRIDE]);
            COND_SHIFT:      cond_met = (config_out.shift == exp_field[FIELD_SHIFT]);
            default:         cond_met = 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int cond, input string what);
        int cycles;
        cycles = 0;
        while (!cond_met(cond) && cycles < TIMEOUT_CYCLES) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (!cond_met(cond)) begin
            $display("Timed out waiting for %s", what);
            timeout_count++;
        end
    endtask

    task automatic apply_reset();
        areset_csr_engine = 1'b1;
        repeat (4) @(negedge ap_clk);
        areset_csr_engine = 1'b0;
    endtask

    task automatic set_row(input int idx, input logic [DEST_ID_W-1:0] dest,
                           input logic [FIELD_SEL_W-1:0] sel, input logic accept);
        stim_table[idx].dest_id   = dest;
        stim_table[idx].field_sel = sel;
        stim_table[idx].data      = $random(seed);
        stim_table[idx].accept    = accept;
    endtask

    // One strobe cycle, then idle
    task automatic send_packet(input stim_row_t row);
        @(negedge ap_clk);
        response_memory_in.valid             = 1'b1;
        response_memory_in.payload.dest_id   = row.dest_id;
        response_memory_in.payload.field_sel = row.field_sel;
        response_memory_in.payload.data      = row.data;
        @(negedge ap_clk);
        response_memory_in.valid = 1'b0;
    endtask

    task automatic apply_expected(input stim_row_t row);
        if (row.accept) begin
            exp_field[row.field_sel] = row.data;
        end
    endtask

    // Back-pressure packets cycle through the six fields
    task automatic send_fill_packet(input int idx);
        stim_row_t row;
        row.dest_id   = ENGINE_ID;
        row.field_sel = FIELD_SEL_W'(idx % NUM_FIELDS);
        row.data      = $random(seed);
        row.accept    = (idx < FIFO_DEPTH);
        send_packet(row);
        apply_expected(row);
    endtask

    task automatic check_config();
        check_value("config_out.index_start", config_out.index_start,
                    exp_field[FIELD_INDEX_START]);
        check_value("config_out.index_end", config_out.index_end, exp_field[FIELD_INDEX_END]);
        check_value("config_out.array_pointer", config_out.array_pointer,
                    exp_field[FIELD_ARRAY_POINTER]);
        check_value("config_out.array_size", config_out.array_size,
                    exp_field[FIELD_ARRAY_SIZE]);
        check_value("config_out.stride", config_out.stride, exp_field[FIELD_STRIDE]);
        check_value("config_out.shift", config_out.shift, exp_field[FIELD_SHIFT]);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        stim_row_t marker;
        seed               = 7231;
        mismatch_count     = 0;
        timeout_count      = 0;
        areset_csr_engine  = 1'b1;
        response_memory_in = '0;
        response_pop_en    = 1'b0;

        // Foreign destinations and codes 6/7 must leave the config alone
        // Each foreign row follows the real packet for the same field
        set_row(0, 4'd3, FIELD_INDEX_START, 1'b1);
        set_row(1, 4'd3, FIELD_INDEX_END, 1'b1);
        set_row(2, 4'd5, FIELD_INDEX_END, 1'b0);
        set_row(3, 4'd3, 3'd6, 1'b0);
        set_row(4, 4'd3, FIELD_ARRAY_POINTER, 1'b1);
        set_row(5, 4'd3, FIELD_ARRAY_SIZE, 1'b1);
        set_row(6, 4'd3, FIELD_STRIDE, 1'b1);
        set_row(7, 4'd0, FIELD_STRIDE, 1'b0);
        set_row(8, 4'd3, 3'd7, 1'b0);
        set_row(9, 4'd3, FIELD_SHIFT, 1'b1);
        // Stride overwrite
        set_row(10, 4'd3, FIELD_STRIDE, 1'b1);
        for (int i = 0; i < NUM_FIELDS; i++) begin
            exp_field[i] = '0;
        end

        apply_reset();
        check_value("fifo_setup_signal", fifo_setup_signal, 1);
        check_value("done_out", done_out, 0);
        check_value("config_out.valid", config_out.valid, 0);
        check_value("fifo_state.empty", fifo_state.empty, 1);
        wait_until(COND_SETUP_DONE, "FIFO setup period to end");

        response_pop_en = 1'b1;
        for (int i = 0; i < LOAD_ROWS; i++) begin
            send_packet(stim_table[i]);
            apply_expected(stim_table[i]);
        end
        wait_until(COND_DONE, "done_out after the configuration load");
        check_value("done_out", done_out, 1);
        check_value("config_out.valid", config_out.valid, 1);
        check_config();

        send_packet(stim_table[LOAD_ROWS]);
        apply_expected(stim_table[LOAD_ROWS]);
        wait_until(COND_STRIDE, "the stride overwrite");
        check_value("config_out.stride", config_out.stride, exp_field[FIELD_STRIDE]);
        check_value("done_out", done_out, 1);

        // Fresh reset, FIFO fills with pop disabled
        response_pop_en = 1'b0;
        apply_reset();
        wait_until(COND_SETUP_DONE, "FIFO setup period after second reset");
        for (int i = 0; i < PROG_THRESH; i++) begin
            send_fill_packet(i);
        end
        wait_until(COND_PROG_FULL, "prog_full");
        check_value("fifo_state.prog_full", fifo_state.prog_full, 1);
        check_value("fifo_state.full", fifo_state.full, 0);
        for (int i = PROG_THRESH; i < FIFO_DEPTH + EXTRA_PACKETS; i++) begin
            send_fill_packet(i);
        end
        wait_until(COND_FULL, "full");
        check_value("fifo_state.full", fifo_state.full, 1);

        response_pop_en = 1'b1;
        wait_until(COND_EMPTY, "the FIFO to drain");
        // In-order marker shows that every earlier packet has landed
        marker.dest_id   = ENGINE_ID;
        marker.field_sel = FIELD_SHIFT;
        marker.data      = ~exp_field[FIELD_SHIFT];
        marker.accept    = 1'b1;
        send_packet(marker);
        apply_expected(marker);
        wait_until(COND_SHIFT, "the marker packet");
        check_config();
        check_value("fifo_state.empty", fifo_state.empty, 1);
        check_value("done_out", done_out, 1);

        $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
